// ==== Bender.yml ====
package:
  name: alien_formation

sources:
  - files:
      - verilog/invaders_pkg.sv
      - verilog/formation_motion.sv
      - verilog/formation_raster.sv
      - verilog/alien_formation.sv

  - target: test
    files:
      - testbench/alien_formation_properties.sv
      - testbench/tb_alien_formation.sv

  - target: simulation
    files:
      - testbench/alien_formation_properties.sv
      - testbench/tb_alien_formation.sv

// ==== files.f ====
verilog/invaders_pkg.sv
verilog/formation_motion.sv
verilog/formation_raster.sv
verilog/alien_formation.sv
testbench/alien_formation_properties.sv
testbench/tb_alien_formation.sv

// ==== testbench/alien_formation_properties.sv ====
// Alien row reference model and checks

module alien_formation_properties #(
    parameter int march_period = invaders_pkg::MARCH_PERIOD
) (
    input logic                                clk,
    input logic                                rst,
    input invaders_pkg::coord_t                pixel_row,
    input invaders_pkg::coord_t                pixel_column,
    input invaders_pkg::coord_t                origin_row,
    input invaders_pkg::coord_t                origin_col,
    input logic [3:0]                          pixel_value,
    input logic [invaders_pkg::SLOT_COUNT-1:0] slot_active,
    input logic                                invaded
);

    // Goes high once a reset clock has loaded the model
    logic model_valid = 1'b0;

    int error_count = 0;

    // Clocks seen with rst low, before the current edge
    int unsigned edge_count;

    invaders_pkg::coord_t     m_row;
    invaders_pkg::coord_t     m_col;
    invaders_pkg::march_dir_t m_dir;
    logic                     tick_due;

    logic [invaders_pkg::SLOT_COUNT-1:0] exp_active;
    logic [3:0]                          exp_pixel;

    // Origin moves on rst-low clocks P+1, 2P+1, 3P+1 and so on
    assign tick_due = (edge_count >= march_period) && ((edge_count % march_period) == 0);

    always @(posedge clk)
    begin
        if (rst)
        begin
            model_valid <= 1'b1;
            edge_count  <= 0;
            m_row       <= invaders_pkg::START_ROW;
            m_col       <= invaders_pkg::START_COL;
            m_dir       <= invaders_pkg::march_right;
        end
        else
        begin
            edge_count <= edge_count + 1;
            if (tick_due && m_dir == invaders_pkg::march_right)
            begin
                if (m_col > invaders_pkg::RIGHT_LIMIT)
                begin
                    m_row <= m_row + invaders_pkg::DROP_STEP;
                    m_dir <= invaders_pkg::march_left;
                end
                else
                    m_col <= m_col + invaders_pkg::MARCH_STEP;
            end
            else if (tick_due)
            begin
                if (m_col < invaders_pkg::LEFT_LIMIT)
                begin
                    m_row <= m_row + invaders_pkg::DROP_STEP;
                    m_dir <= invaders_pkg::march_right;
                end
                else
                    m_col <= m_col - invaders_pkg::MARCH_STEP;
            end
        end
    end

    // Expected hit boxes and pixel from signed offsets
    always_comb
    begin
        int dr;
        int dc;
        exp_active = '0;
        exp_pixel  = 4'b0000;
        dr = int'(pixel_row) - int'(m_row);
        for (int k = 0; k < invaders_pkg::SLOT_COUNT; k++)
        begin
            dc = int'(pixel_column) - int'(m_col) - k * int'(invaders_pkg::SLOT_PITCH);
            if (dr >= 1 && dr <= 16 && dc >= 1 && dc <= 16)
            begin
                exp_active[k] = 1'b1;
                if (invaders_pkg::alien_shape[dr - 1][dc - 1])
                    exp_pixel = invaders_pkg::PIXEL_ON;
            end
        end
    end

    a_start_origin: assert property (@(posedge clk)
        (model_valid && edge_count <= march_period) |->
            (origin_row == invaders_pkg::START_ROW && origin_col == invaders_pkg::START_COL))
        else begin
            error_count++;
            $error("ERROR t=%0t origin_row,origin_col got (%0d,%0d) expected (%0d,%0d)",
                   $time, $sampled(origin_row), $sampled(origin_col),
                   invaders_pkg::START_ROW, invaders_pkg::START_COL);
        end

    a_slot_active: assert property (@(posedge clk)
        model_valid |-> (slot_active == exp_active))
        else begin
            error_count++;
            $error("ERROR t=%0t slot_active got %b expected %b", $time,
                   $sampled(slot_active), $sampled(exp_active));
        end

    a_single_slot: assert property (@(posedge clk)
        model_valid |-> $onehot0(slot_active))
        else begin
            error_count++;
            $error("ERROR t=%0t slot_active got %b expected at most one bit set", $time,
                   $sampled(slot_active));
        end

    a_pixel_value: assert property (@(posedge clk)
        model_valid |-> (pixel_value == exp_pixel))
        else begin
            error_count++;
            $error("ERROR t=%0t pixel_value got %h expected %h", $time,
                   $sampled(pixel_value), $sampled(exp_pixel));
        end

    a_invaded: assert property (@(posedge clk)
        model_valid |-> (invaded == (m_row > invaders_pkg::INVADE_ROW)))
        else begin
            error_count++;
            $error("ERROR t=%0t invaded got %b expected %b", $time,
                   $sampled(invaded), $sampled(m_row > invaders_pkg::INVADE_ROW));
        end

    a_invaded_in_reset: assert property (@(posedge clk)
        (model_valid && rst) |-> !invaded)
        else begin
            error_count++;
            $error("ERROR t=%0t invaded got %b expected 0 in reset", $time,
                   $sampled(invaded));
        end

    // Landing is final
    a_invaded_sticky: assert property (@(posedge clk) disable iff (rst)
        (model_valid && invaded) |=> invaded)
        else begin
            error_count++;
            $error("ERROR t=%0t invaded got %b expected 1 after landing", $time,
                   $sampled(invaded));
        end

endmodule

bind alien_formation alien_formation_properties #(
    .march_period (march_period)
) u_props (
    .clk          (clk),
    .rst          (rst),
    .pixel_row    (pixel_row),
    .pixel_column (pixel_column),
    .origin_row   (origin_row),
    .origin_col   (origin_col),
    .pixel_value  (pixel_value),
    .slot_active  (slot_active),
    .invaded      (invaded)
);

// ==== testbench/tb_alien_formation.sv ====
// Alien row testbench

module tb_alien_formation;

    localparam int tb_march_period = 8;
    localparam int clk_period      = 100;

    // First sweep 23 ticks, then 15 sweeps of 42 up to landing, then one more sweep
    localparam int  expected_ticks = 700;
    localparam time watchdog_time  = 2 * expected_ticks * tb_march_period * clk_period;

    logic                                clk;
    logic                                rst;
    invaders_pkg::coord_t                pixel_row;
    invaders_pkg::coord_t                pixel_column;
    logic [3:0]                          pixel_value;
    logic [invaders_pkg::SLOT_COUNT-1:0] slot_active;
    logic                                invaded;

    alien_formation #(
        .march_period (tb_march_period)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .pixel_value  (pixel_value),
        .slot_active  (slot_active),
        .invaded      (invaded)
    );

    always #(clk_period / 2) clk = ~clk;

    // Mostly near the row so every slot and shape bit gets hit
    task automatic drive_near_origin(
        input invaders_pkg::coord_t base_row,
        input invaders_pkg::coord_t base_col
    );
        int col_span;
        col_span = invaders_pkg::SLOT_COUNT * int'(invaders_pkg::SLOT_PITCH) + 8;
        if (($urandom % 16) == 0)
        begin
            // Anywhere on screen
            pixel_row    <= invaders_pkg::coord_t'($urandom);
            pixel_column <= invaders_pkg::coord_t'($urandom);
        end
        else
        begin
            pixel_row    <= base_row + invaders_pkg::coord_t'($urandom % 20);
            pixel_column <= base_col + invaders_pkg::coord_t'($urandom % col_span);
        end
    endtask

    initial
    begin
        invaders_pkg::coord_t landed_row;
        void'($urandom(32'h0f7d_f0fc));
        clk          = 1'b0;
        rst          = 1'b1;
        pixel_row    = '0;
        pixel_column = '0;

        repeat (3)
        begin
            @(posedge clk);
            drive_near_origin(invaders_pkg::START_ROW, invaders_pkg::START_COL);
        end
        rst <= 1'b0;

        // March until the row has landed
        while (!(UUT.u_props.m_row > invaders_pkg::INVADE_ROW))
        begin
            @(posedge clk);
            drive_near_origin(UUT.u_props.m_row, UUT.u_props.m_col);
        end
        landed_row = UUT.u_props.m_row;

        // One more full sweep, up to the next drop
        while (UUT.u_props.m_row == landed_row)
        begin
            @(posedge clk);
            drive_near_origin(UUT.u_props.m_row, UUT.u_props.m_col);
        end

        repeat (4)
        begin
            @(posedge clk);
            drive_near_origin(UUT.u_props.m_row, UUT.u_props.m_col);
        end
        @(negedge clk);

        if (UUT.u_props.error_count == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures during the run");
        end
    end

    // Stop at the first failed assertion
    initial
    begin
        wait (UUT.u_props.error_count != 0);
        $display("FAIL: see errors above");
        $fatal(1, "assertion failed, run stopped");
    end

    initial
    begin
        #(watchdog_time);
        $display("FAIL: see errors above");
        $fatal(1, "timeout: the row did not finish its march in time");
    end

endmodule

// ==== verilog/alien_formation.sv ====
// Marching alien row

module alien_formation #(
    parameter int march_period = invaders_pkg::MARCH_PERIOD
) (
    input  logic                                clk,
    input  logic                                rst,
    input  invaders_pkg::coord_t                pixel_row,
    input  invaders_pkg::coord_t                pixel_column,
    output logic [3:0]                          pixel_value,
    output logic [invaders_pkg::SLOT_COUNT-1:0] slot_active,
    output logic                                invaded
);

    // Top left corner of slot 0
    invaders_pkg::coord_t origin_row;
    invaders_pkg::coord_t origin_col;

    formation_motion #(
        .march_period (march_period)
    ) u_motion (
        .clk        (clk),
        .rst        (rst),
        .origin_row (origin_row),
        .origin_col (origin_col),
        .invaded    (invaded)
    );

    // Purely combinational, zero latency from scan position
    formation_raster u_raster (
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .slot_active  (slot_active),
        .pixel_value  (pixel_value)
    );

endmodule

// ==== verilog/formation_motion.sv ====
// Alien row march control

module formation_motion #(
    parameter int march_period = invaders_pkg::MARCH_PERIOD
) (
    input  logic                 clk,
    input  logic                 rst,
    output invaders_pkg::coord_t origin_row,
    output invaders_pkg::coord_t origin_col,
    output logic                 invaded
);

    // Period counter, wide enough for any march_period
    logic [$clog2(march_period + 1)-1:0] march_count;
    logic                                count_last;

    // One cycle pulse, one clock after the counter wraps
    logic march_tick;

    invaders_pkg::march_dir_t march_dir;

    // Edge tests for the current origin
    logic at_right_edge;
    logic at_left_edge;

    assign count_last = (march_count == ($bits(march_count))'(march_period - 1));

    assign at_right_edge = (origin_col > invaders_pkg::RIGHT_LIMIT);
    assign at_left_edge  = (origin_col < invaders_pkg::LEFT_LIMIT);

    // Counter and tick
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            march_count <= '0;
            march_tick  <= 1'b0;
        end
        else
        begin
            march_tick <= count_last;
            if (count_last)
                march_count <= '0;
            else
                march_count <= march_count + 1'b1;
        end
    end

    // Origin and direction state
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            origin_row <= invaders_pkg::START_ROW;
            origin_col <= invaders_pkg::START_COL;
            march_dir  <= invaders_pkg::march_right;
        end
        else if (march_tick)
        begin
            case (march_dir)
                invaders_pkg::march_right:
                begin
                    if (at_right_edge)
                    begin
                        // Drop a step and head back left
                        origin_row <= origin_row + invaders_pkg::DROP_STEP;
                        march_dir  <= invaders_pkg::march_left;
                    end
                    else
                    begin
                        origin_col <= origin_col + invaders_pkg::MARCH_STEP;
                    end
                end
                invaders_pkg::march_left:
                begin
                    if (at_left_edge)
                    begin
                        origin_row <= origin_row + invaders_pkg::DROP_STEP;
                        march_dir  <= invaders_pkg::march_right;
                    end
                    else
                    begin
                        origin_col <= origin_col - invaders_pkg::MARCH_STEP;
                    end
                end
            endcase
        end
    end

    // Row has reached the defenders
    assign invaded = (origin_row > invaders_pkg::INVADE_ROW);

endmodule

// ==== verilog/formation_raster.sv ====
// Alien row hit boxes and pixel colour

module formation_raster (
    input  invaders_pkg::coord_t                        pixel_row,
    input  invaders_pkg::coord_t                        pixel_column,
    input  invaders_pkg::coord_t                        origin_row,
    input  invaders_pkg::coord_t                        origin_col,
    output logic [invaders_pkg::SLOT_COUNT-1:0]         slot_active,
    output logic [3:0]                                  pixel_value
);

    // Row offset inside the sprite, shared by all slots
    invaders_pkg::coord_t local_row;
    logic                 row_hit;

    // Column offset inside each slot's sprite
    invaders_pkg::coord_t local_col [invaders_pkg::SLOT_COUNT];

    // Shape bit at each slot's local coordinate
    logic [invaders_pkg::SLOT_COUNT-1:0] slot_lit;

    // Offsets wrap below zero, so one unsigned compare
    // covers both ends of the 1 to 16 window
    always_comb
    begin
        local_row = pixel_row - origin_row - invaders_pkg::coord_t'(1);
        row_hit   = (local_row < invaders_pkg::SPRITE_SIZE);
    end

    always_comb
    begin
        for (int k = 0; k < invaders_pkg::SLOT_COUNT; k++)
        begin
            local_col[k] = pixel_column - origin_col
                         - invaders_pkg::coord_t'(k * invaders_pkg::SLOT_PITCH)
                         - invaders_pkg::coord_t'(1);

            slot_active[k] = row_hit && (local_col[k] < invaders_pkg::SPRITE_SIZE);

            // Only meaningful inside the box, masked below
            slot_lit[k] = invaders_pkg::alien_shape[local_row[3:0]][local_col[k][3:0]];
        end
    end

    // Slots never overlap, so at most one term survives
    always_comb
    begin
        if (|(slot_active & slot_lit))
            pixel_value = invaders_pkg::PIXEL_ON;
        else
            pixel_value = 4'b0000;
    end

endmodule

// ==== verilog/invaders_pkg.sv ====
// Alien row shared definitions

package invaders_pkg;

    // Screen coordinate, used for rows and columns
    typedef logic [11:0] coord_t;

    // Sprite geometry
    localparam coord_t SPRITE_SIZE = 12'd16;
    localparam int     SLOT_COUNT  = 5;
    localparam coord_t SLOT_PITCH  = 12'd32;

    // Origin of slot 0 after reset
    localparam coord_t START_ROW = 12'd20;
    localparam coord_t START_COL = 12'd246;

    // March geometry
    localparam coord_t MARCH_STEP = 12'd12;
    localparam coord_t DROP_STEP  = 12'd24;

    // Turn points for the origin column, compared strictly
    localparam coord_t LEFT_LIMIT  = 12'd21;
    localparam coord_t RIGHT_LIMIT = 12'd500;

    // Origin row beyond which the row has landed
    localparam coord_t INVADE_ROW = 12'd380;

    // About half a second at a 31.5 MHz pixel clock
    localparam int MARCH_PERIOD = 16_000_000;

    // Lit pixel value
    localparam logic [3:0] PIXEL_ON = 4'b1111;

    // Alien picture, row 0 at the top
    // Bit 0 of each row is the leftmost column
    // Rows come in identical pairs, as in the original artwork
    localparam logic [15:0] alien_shape [0:15] = '{
        16'h03c0,
        16'h03c0,
        16'h0ff0,
        16'h0ff0,
        16'h3ffc,
        16'h3ffc,
        16'hf3cf,
        16'hf3cf,
        16'hffff,
        16'hffff,
        16'h0c30,
        16'h0c30,
        16'h33cc,
        16'h33cc,
        16'hcc33,
        16'hcc33
    };

    // Sideways direction of the march
    typedef enum logic {
        march_right,
        march_left
    } march_dir_t;

endpackage
